/* verilog/gfx_macros.svh */
`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// framebuffer geometry in pixels.
`define GFX_FB_WIDTH 16
`define GFX_FB_HEIGHT 12

`define GFX_X_BITS 4 // enough for 0..15.
`define GFX_Y_BITS 4 // enough for 0..11.

`define GFX_FB_WORDS 192
`define GFX_FB_ADDR_BITS 8

// the top bus address bit selects the framebuffer window (1) or the registers (0).
`define GFX_WB_ADDR_BITS 9

// one third of the width, rounded down.
`define GFX_BAR_WIDTH 5

`endif

/* verilog/gfx_pkg.sv */
`include "gfx_macros.svh"

package gfx_pkg;

  // one RGB444 pixel, with red in the top nibble.
  typedef struct packed {
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;
  } pixel_t;

  // register words live below the framebuffer window.
  // the index covers the low address bits of a register access.
  typedef enum logic [`GFX_FB_ADDR_BITS-1:0] {
    REG_CTRL   = 8'd0, // bit 0 starts a fill.
    REG_STATUS = 8'd1  // bit 0 busy, bit 1 done.
  } reg_index_t;

endpackage

/* verilog/gfx_pixel_if.sv */
`timescale 1ns/1ps

`include "gfx_macros.svh"

interface gfx_pixel_if;
  import gfx_pkg::*;

  logic [`GFX_X_BITS-1:0] x;
  logic [`GFX_Y_BITS-1:0] y;
  pixel_t                 color;
  logic                   valid;
  logic                   last; // high while the final pixel of the frame is shown.
  logic                   inc;  // consumer takes the pixel when valid is also high.

  // the generator presents pixels.
  modport source (
    output x,
    output y,
    output color,
    output valid,
    output last,
    input  inc
  );

  // the control block turns them into memory writes.
  modport sink (
    input  x,
    input  y,
    input  color,
    input  valid,
    input  last,
    output inc
  );

endinterface

/* verilog/gfx_test_pattern.sv */
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_test_pattern (
  input logic       clk,
  input logic       reset,
  input logic       restart,
  gfx_pixel_if.source pix
);
  import gfx_pkg::*;

  localparam logic [`GFX_X_BITS-1:0] MAX_X = `GFX_X_BITS'(`GFX_FB_WIDTH - 1);
  localparam logic [`GFX_Y_BITS-1:0] MAX_Y = `GFX_Y_BITS'(`GFX_FB_HEIGHT - 1);
  localparam logic [`GFX_X_BITS-1:0] GRN_START = `GFX_X_BITS'(`GFX_BAR_WIDTH);
  localparam logic [`GFX_X_BITS-1:0] BLU_START = `GFX_X_BITS'(2 * `GFX_BAR_WIDTH);

  logic [`GFX_X_BITS-1:0] next_x;
  logic [`GFX_Y_BITS-1:0] next_y;
  logic                   take;
  pixel_t                 next_color;

  assign take = pix.valid && pix.inc;

  // the final pixel is the bottom right corner.
  assign pix.last = pix.valid && (pix.x == MAX_X) && (pix.y == MAX_Y);

  // raster order, left to right and then top to bottom.
  always_comb begin
    next_x = pix.x;
    next_y = pix.y;
    if (restart) begin
      next_x = '0;
      next_y = '0;
    end else if (take) begin
      if (pix.x == MAX_X) begin
        next_x = '0;
        if (pix.y == MAX_Y) begin
          next_y = '0; // wraps, but valid drops at the same edge.
        end else begin
          next_y = pix.y + 1'b1;
        end
      end else begin
        next_x = pix.x + 1'b1;
      end
    end
  end

  // The bar color is taken from the coordinate that is about to be loaded,
  // so that once registered it matches x and y on the same cycle.
  always_comb begin
    next_color = '0;
    if (next_x < GRN_START) begin
      next_color.red = 4'hf;
    end else if (next_x < BLU_START) begin
      next_color.green = 4'hf;
    end else begin
      next_color.blue = 4'hf;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pix.x     <= '0;
      pix.y     <= '0;
      pix.valid <= 1'b0;
    end else begin
      pix.x <= next_x;
      pix.y <= next_y;
      if (restart) begin
        pix.valid <= 1'b1; // (0,0) shows one cycle after restart.
      end else if (take && pix.last) begin
        pix.valid <= 1'b0; // frame is finished, wait for the next restart.
      end
    end
  end

  always_ff @(posedge clk) begin
    pix.color <= next_color;
  end

endmodule

/* verilog/gfx_framebuffer.sv */
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_framebuffer (
  input  logic                         clk,
  input  logic                         we,
  input  logic [`GFX_FB_ADDR_BITS-1:0] waddr,
  input  gfx_pkg::pixel_t              wdata,
  input  logic [`GFX_FB_ADDR_BITS-1:0] raddr,
  output gfx_pkg::pixel_t              rdata
);
  import gfx_pkg::*;

  // one pixel per word, y times width plus x.
  pixel_t mem [`GFX_FB_WORDS];

  logic waddr_ok;
  logic raddr_ok;

  // The address space is wider than the screen; words past the
  // last pixel are not backed by storage.
  assign waddr_ok = waddr < `GFX_FB_ADDR_BITS'(`GFX_FB_WORDS);
  assign raddr_ok = raddr < `GFX_FB_ADDR_BITS'(`GFX_FB_WORDS);

  always_ff @(posedge clk) begin
    if (we && waddr_ok) begin
      mem[waddr] <= wdata;
    end
  end

  // synchronous read, data shows the cycle after the address.
  always_ff @(posedge clk) begin
    if (raddr_ok) begin
      rdata <= mem[raddr];
    end else begin
      rdata <= '0; // outside the screen reads as black.
    end
  end

endmodule

/* verilog/gfx_fill_ctrl.sv */
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_fill_ctrl (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`GFX_WB_ADDR_BITS-1:0] wb_adr,
  input  logic [31:0]                  wb_dat_w,
  output logic [31:0]                  wb_dat_r,
  output logic                         wb_ack,
  gfx_pixel_if.sink                    pix,
  output logic                         restart,
  output logic                         fb_we,
  output logic [`GFX_FB_ADDR_BITS-1:0] fb_waddr,
  output gfx_pkg::pixel_t              fb_wdata,
  output logic [`GFX_FB_ADDR_BITS-1:0] fb_raddr,
  input  gfx_pkg::pixel_t              fb_rdata
);
  import gfx_pkg::*;

  typedef enum logic {
    BUS_IDLE,
    BUS_ACTIVE
  } bus_state_t;

  typedef enum logic {
    FILL_IDLE,
    FILL_BUSY
  } fill_state_t;

  bus_state_t  bus_state;
  logic        bus_phase; // second cycle of an access, ack follows.
  fill_state_t fill_state;
  logic        done;
  logic        busy;

  logic                         fb_sel;
  reg_index_t                   reg_idx;
  logic                         bus_commit;
  logic                         host_fb_wr;
  logic                         start_req;
  logic                         gen_wr;
  logic [`GFX_FB_ADDR_BITS-1:0] gen_addr;
  logic [31:0]                  rd_word;

  // address decode, held stable by the master until ack.
  assign fb_sel  = wb_adr[`GFX_WB_ADDR_BITS-1];
  assign reg_idx = reg_index_t'(wb_adr[`GFX_FB_ADDR_BITS-1:0]);

  // an access takes effect at the edge that raises ack.
  assign bus_commit = (bus_state == BUS_ACTIVE) && bus_phase;
  assign host_fb_wr = bus_commit && wb_we && fb_sel;
  assign start_req  = bus_commit && wb_we && !fb_sel && (reg_idx == REG_CTRL) && wb_dat_w[0];

  assign busy = (fill_state == FILL_BUSY);

  // The host write owns the memory port for its one cycle,
  // which holds the generator on its current pixel.
  assign pix.inc = busy && !host_fb_wr;
  assign gen_wr  = busy && pix.valid && pix.inc;

  assign gen_addr = `GFX_FB_ADDR_BITS'(pix.y * `GFX_FB_WIDTH) + `GFX_FB_ADDR_BITS'(pix.x);

  // Two cycle bus sequencer. The first cycle decodes, the second
  // lets the synchronous memory read settle before ack.
  always_ff @(posedge clk) begin
    if (reset) begin
      bus_state <= BUS_IDLE;
      bus_phase <= 1'b0;
      wb_ack    <= 1'b0;
    end else begin
      wb_ack <= 1'b0;
      case (bus_state)
        BUS_IDLE: begin
          // a request still held during its own ack is not a new one.
          if (wb_cyc && wb_stb && !wb_ack) begin
            bus_state <= BUS_ACTIVE;
            bus_phase <= 1'b0;
          end
        end
        BUS_ACTIVE: begin
          if (!bus_phase) begin
            bus_phase <= 1'b1;
          end else begin
            bus_state <= BUS_IDLE;
            bus_phase <= 1'b0;
            wb_ack    <= 1'b1;
          end
        end
        default: bus_state <= BUS_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      fill_state <= FILL_IDLE;
      done       <= 1'b0;
      restart    <= 1'b0;
    end else begin
      restart <= 1'b0;
      case (fill_state)
        FILL_IDLE: begin
          if (start_req) begin
            fill_state <= FILL_BUSY;
            restart    <= 1'b1; // generator shows (0,0) one cycle after this pulse.
            done       <= 1'b0;
          end
        end
        FILL_BUSY: begin
          // start writes are dropped here, the fill simply runs on.
          if (gen_wr && pix.last) begin
            fill_state <= FILL_IDLE;
            done       <= 1'b1;
          end
        end
        default: fill_state <= FILL_IDLE;
      endcase
    end
  end

  // memory write port, host first.
  always_comb begin
    fb_we    = host_fb_wr || gen_wr;
    fb_waddr = gen_addr;
    fb_wdata = pix.color;
    if (host_fb_wr) begin
      fb_waddr = wb_adr[`GFX_FB_ADDR_BITS-1:0];
      fb_wdata = pixel_t'(wb_dat_w[$bits(pixel_t)-1:0]);
    end
  end

  // The read address follows the bus directly; the word captured at the
  // ack edge is the one returned.
  assign fb_raddr = wb_adr[`GFX_FB_ADDR_BITS-1:0];

  always_comb begin
    rd_word = '0;
    if (fb_sel) begin
      rd_word[$bits(pixel_t)-1:0] = fb_rdata; // upper bits stay zero.
    end else begin
      case (reg_idx)
        REG_STATUS: rd_word[1:0] = {done, busy};
        default:    rd_word = '0; // control and unused words read as zero.
      endcase
    end
  end

  assign wb_dat_r = wb_ack ? rd_word : '0;

endmodule

/* verilog/gfx_top.sv */
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_top (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         wb_cyc,
  input  logic                         wb_stb,
  input  logic                         wb_we,
  input  logic [`GFX_WB_ADDR_BITS-1:0] wb_adr,
  input  logic [31:0]                  wb_dat_w,
  output logic [31:0]                  wb_dat_r,
  output logic                         wb_ack
);
  import gfx_pkg::*;

  // pixel stream from the generator to the control block.
  gfx_pixel_if pix_bus ();

  logic                         restart;
  logic                         fb_we;
  logic [`GFX_FB_ADDR_BITS-1:0] fb_waddr;
  pixel_t                       fb_wdata;
  logic [`GFX_FB_ADDR_BITS-1:0] fb_raddr;
  pixel_t                       fb_rdata;

  gfx_test_pattern i_gfx_test_pattern (
    .clk     (clk),
    .reset   (reset),
    .restart (restart),
    .pix     (pix_bus.source)
  );

  // bus slave, register file and write port arbiter.
  gfx_fill_ctrl i_gfx_fill_ctrl (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack),
    .pix      (pix_bus.sink),
    .restart  (restart),
    .fb_we    (fb_we),
    .fb_waddr (fb_waddr),
    .fb_wdata (fb_wdata),
    .fb_raddr (fb_raddr),
    .fb_rdata (fb_rdata)
  );

  gfx_framebuffer i_gfx_framebuffer (
    .clk   (clk),
    .we    (fb_we),
    .waddr (fb_waddr),
    .wdata (fb_wdata),
    .raddr (fb_raddr),
    .rdata (fb_rdata)
  );

endmodule

/* dv/gfx_tb.sv */
`timescale 1ns/1ps

`include "gfx_macros.svh"

module gfx_tb;

  localparam int ACK_LIMIT = 20;   // cycles a single access may wait for ack.
  localparam int POLL_LIMIT = 200; // status reads before a fill counts as stuck.
  localparam int IDLE_POLLS = 50;  // status reads that span longer than one whole fill.
  localparam int MAX_STEPS = 32;
  localparam logic [`GFX_WB_ADDR_BITS-1:0] CTRL_ADR = 'd0;
  localparam logic [`GFX_WB_ADDR_BITS-1:0] STATUS_ADR = 'd1;
  localparam logic [`GFX_WB_ADDR_BITS-1:0] SPARE_ADR = 'd5;

  logic                         clk;
  logic                         reset;
  logic                         wb_cyc;
  logic                         wb_stb;
  logic                         wb_we;
  logic [`GFX_WB_ADDR_BITS-1:0] wb_adr;
  logic [31:0]                  wb_dat_w;
  logic [31:0]                  wb_dat_r;
  logic                         wb_ack;

  // the stimulus table holds one row per bus access.
  int                           step_test [MAX_STEPS];
  logic                         step_write [MAX_STEPS];
  logic [`GFX_WB_ADDR_BITS-1:0] step_adr [MAX_STEPS];
  logic [31:0]                  step_wdata [MAX_STEPS];
  logic [31:0]                  step_exp [MAX_STEPS];
  int                           num_steps = 0;

  int errors = 0;
  int checks = 0;
  int tests = 0;
  int test_base = 0;

  gfx_top i_gfx_top (
    .clk      (clk),
    .reset    (reset),
    .wb_cyc   (wb_cyc),
    .wb_stb   (wb_stb),
    .wb_we    (wb_we),
    .wb_adr   (wb_adr),
    .wb_dat_w (wb_dat_w),
    .wb_dat_r (wb_dat_r),
    .wb_ack   (wb_ack)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, name, got, exp);
    end
  endtask

  // framebuffer window address of pixel (x,y).
  function automatic logic [`GFX_WB_ADDR_BITS-1:0] fb_adr(input int x, input int y);
    fb_adr = '0;
    fb_adr[`GFX_WB_ADDR_BITS-1] = 1'b1;
    fb_adr[`GFX_FB_ADDR_BITS-1:0] = `GFX_FB_ADDR_BITS'(y * `GFX_FB_WIDTH + x);
  endfunction

  // red, green and blue bars from left to right at full intensity.
  function automatic logic [31:0] bar_color(input int x);
    if (x < `GFX_BAR_WIDTH) begin
      bar_color = 32'h0000_0f00;
    end else if (x < 2 * `GFX_BAR_WIDTH) begin
      bar_color = 32'h0000_00f0;
    end else begin
      bar_color = 32'h0000_000f;
    end
  endfunction

  // called on a falling edge; returns on a falling edge.
  task automatic bus_access(input logic write, input logic [`GFX_WB_ADDR_BITS-1:0] adr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    rdata = '0;
    wb_cyc = 1'b1;
    wb_stb = 1'b1;
    wb_we = write;
    wb_adr = adr;
    wb_dat_w = wdata;
    while (!ok && cycles < ACK_LIMIT) begin
      @(negedge clk);
      cycles++;
      if (wb_ack) begin
        ok = 1'b1;
        rdata = wb_dat_r; // stable in the middle of the ack cycle.
      end
    end
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    if (ok) begin
      check("wb_ack latency", cycles, 3); // ack two edges after the request edge.
    end else begin
      errors++;
      $display("no ack within %0d cycles for the access at address %h", ACK_LIMIT, adr);
    end
    @(negedge clk); // one idle cycle between accesses.
    if (ok) begin
      check("wb_ack after the ack cycle", wb_ack, 1'b0); // ack lasts a single cycle.
    end
  endtask

  task automatic bus_read(input logic [`GFX_WB_ADDR_BITS-1:0] adr, output logic [31:0] data,
                          output logic ok);
    bus_access(1'b0, adr, 32'h0, data, ok);
  endtask

  task automatic bus_write(input logic [`GFX_WB_ADDR_BITS-1:0] adr, input logic [31:0] data,
                           output logic ok);
    logic [31:0] unused;
    bus_access(1'b1, adr, data, unused, ok);
  endtask

  task automatic read_check(input logic [`GFX_WB_ADDR_BITS-1:0] adr, input logic [31:0] exp);
    logic [31:0] data;
    logic        ok;
    bus_read(adr, data, ok);
    if (ok) check($sformatf("wb_dat_r at %h", adr), data, exp);
  endtask

  task automatic wait_fill_done();
    logic [31:0] status;
    logic        rd_ok;
    logic        seen;
    int          polls;
    seen = 1'b0;
    polls = 0;
    while (!seen && polls < POLL_LIMIT) begin
      bus_read(STATUS_ADR, status, rd_ok);
      polls++;
      if (rd_ok && status[1]) seen = 1'b1;
    end
    if (!seen) begin
      errors++;
      $display("the fill did not report done within %0d status reads", POLL_LIMIT);
    end
  endtask

  task automatic add_step(input int test_no, input logic write,
                          input logic [`GFX_WB_ADDR_BITS-1:0] adr,
                          input logic [31:0] wdata, input logic [31:0] exp);
    step_test[num_steps] = test_no;
    step_write[num_steps] = write;
    step_adr[num_steps] = adr;
    step_wdata[num_steps] = wdata;
    step_exp[num_steps] = exp;
    num_steps++;
  endtask

  task automatic run_steps(input int test_no);
    logic ok;
    for (int i = 0; i < num_steps; i++) begin
      if (step_test[i] == test_no) begin
        if (step_write[i]) bus_write(step_adr[i], step_wdata[i], ok);
        else read_check(step_adr[i], step_exp[i]);
      end
    end
  endtask

  task automatic end_test(input int test_no, input string name);
    tests++;
    $display("test %0d (%s): %s, %0d errors", test_no, name,
             (errors == test_base) ? "passed" : "failed", errors - test_base);
    test_base = errors;
  endtask

  initial begin
    logic        ok;
    int          x;
    int          y;
    wb_cyc = 1'b0;
    wb_stb = 1'b0;
    wb_we = 1'b0;
    wb_adr = '0;
    wb_dat_w = '0;
    reset = 1'b1;
    void'($urandom(32'h17dd_47ff));

    // bar edges and corners; expected colors follow the bar rule.
    add_step(3, 1'b0, fb_adr(4, 0), 32'h0, 32'h0000_0f00);
    add_step(3, 1'b0, fb_adr(5, 0), 32'h0, 32'h0000_00f0);
    add_step(3, 1'b0, fb_adr(9, 5), 32'h0, 32'h0000_00f0);
    add_step(3, 1'b0, fb_adr(10, 5), 32'h0, 32'h0000_000f);
    add_step(3, 1'b0, fb_adr(0, 0), 32'h0, 32'h0000_0f00);
    add_step(3, 1'b0, fb_adr(15, 11), 32'h0, 32'h0000_000f);
    add_step(4, 1'b1, fb_adr(2, 3), 32'h0000_0abc, 32'h0);
    add_step(4, 1'b0, fb_adr(2, 3), 32'h0, 32'h0000_0abc);
    add_step(4, 1'b0, fb_adr(1, 3), 32'h0, 32'h0000_0f00);
    add_step(4, 1'b0, fb_adr(3, 3), 32'h0, 32'h0000_0f00);
    add_step(4, 1'b0, fb_adr(2, 2), 32'h0, 32'h0000_0f00);
    add_step(4, 1'b0, fb_adr(2, 4), 32'h0, 32'h0000_0f00);
    add_step(6, 1'b1, SPARE_ADR, 32'hffff_ffff, 32'h0);
    add_step(6, 1'b0, SPARE_ADR, 32'h0, 32'h0);
    add_step(6, 1'b0, CTRL_ADR, 32'h0, 32'h0); // control is write only.
    add_step(6, 1'b1, fb_adr(1, 1), 32'hffff_f123, 32'h0);
    add_step(6, 1'b0, fb_adr(1, 1), 32'h0, 32'h0000_0123);

    repeat (10) @(negedge clk);
    reset = 1'b0;
    @(negedge clk);

    read_check(STATUS_ADR, 32'h0);
    end_test(1, "status after reset");

    bus_write(CTRL_ADR, 32'h1, ok);
    read_check(STATUS_ADR, 32'h1); // busy and not yet done.
    wait_fill_done();
    read_check(STATUS_ADR, 32'h2);
    end_test(2, "fill start and done");

    run_steps(3);
    for (int i = 0; i < 20; i++) begin
      x = $urandom % `GFX_FB_WIDTH;
      y = $urandom % `GFX_FB_HEIGHT;
      read_check(fb_adr(x, y), bar_color(x));
    end
    end_test(3, "pattern readback");

    run_steps(4);
    end_test(4, "host pixel write");

    bus_write(CTRL_ADR, 32'h1, ok);
    bus_write(CTRL_ADR, 32'h1, ok); // lands while busy and is dropped.
    bus_write(fb_adr(7, 11), 32'h0000_0555, ok);
    check("wb_ack of pixel write during fill", ok, 1'b1);
    read_check(STATUS_ADR, 32'h1);
    wait_fill_done();
    for (int i = 0; i < IDLE_POLLS; i++) begin
      read_check(STATUS_ADR, 32'h2); // the dropped start never launches a later fill.
    end
    read_check(fb_adr(2, 3), bar_color(2));
    read_check(fb_adr(7, 11), bar_color(7));
    end_test(5, "start during fill and refill");

    run_steps(6);
    end_test(6, "unused register and upper bits");

    $display("tests run: %0d, checks: %0d, errors: %0d", tests, checks, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

/* build.f */
+incdir+verilog
verilog/gfx_pkg.sv
verilog/gfx_pixel_if.sv
verilog/gfx_test_pattern.sv
verilog/gfx_framebuffer.sv
verilog/gfx_fill_ctrl.sv
verilog/gfx_top.sv
dv/gfx_tb.sv
